//--- flist.f
verilog/opu_pkg.sv
verilog/opu_decode.sv
verilog/opu_execute.sv
verilog/opu_result.sv
verilog/opu_top.sv
test/opu_sva.sv
test/opu_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the operation unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -sv --top-module opu_tb -Mdir obj_dir -f flist.f

status=0
output=$(./obj_dir/Vopu_tb 2>&1) || status=$?
echo "$output"

if [ "$status" -eq 0 ] && grep -q "All tests passed" <<< "$output"; then
    exit 0
fi
exit 1

//--- test/opu_sva.sv
/* Protocol checks for the operation unit
   Handshake stability, command exclusion and completion pulses */
`default_nettype none

module opu_sva (
    input logic            clk,
    input logic            rst_n,
    input logic            cfg_vld,
    input logic            cfg_rdy,
    input opu_pkg::cfg_t   cfg_info,
    input opu_pkg::addr_t  rd0_addr,
    input logic            rd0_addr_vld,
    input logic            rd0_addr_rdy,
    input opu_pkg::word_t  rd0_dat,
    input logic            rd0_dat_vld,
    input logic            rd0_dat_rdy,
    input opu_pkg::addr_t  rd1_addr,
    input logic            rd1_addr_vld,
    input logic            rd1_addr_rdy,
    input opu_pkg::word_t  rd1_dat,
    input logic            rd1_dat_vld,
    input logic            rd1_dat_rdy,
    input opu_pkg::addr_t  wr_addr,
    input opu_pkg::word_t  wr_dat,
    input logic            wr_vld,
    input logic            wr_rdy,
    input logic            done,
    input logic            err
);

    logic in_flight;

    // Set on command transfer, cleared by done
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_flight <= 1'b0;
        end else if (cfg_vld && cfg_rdy) begin
            in_flight <= 1'b1;
        end else if (done) begin
            in_flight <= 1'b0;
        end
    end

    // ============================
    // Command exclusion
    // ============================
    a_cfg_busy: assert property (@(posedge clk) disable iff (!rst_n) in_flight |-> !cfg_rdy)
        else $error("cfg_rdy high while a command is in flight");

    // Valid holds with a stable payload until ready
    a_cfg_hold: assert property (@(posedge clk) disable iff (!rst_n)
        cfg_vld && !cfg_rdy |=> cfg_vld && $stable(cfg_info))
        else $error("command valid or payload changed before transfer");
    a_rd0_addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rd0_addr_vld && !rd0_addr_rdy |=> rd0_addr_vld && $stable(rd0_addr))
        else $error("rd0 address changed before transfer");
    a_rd1_addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rd1_addr_vld && !rd1_addr_rdy |=> rd1_addr_vld && $stable(rd1_addr))
        else $error("rd1 address changed before transfer");
    a_rd0_dat_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rd0_dat_vld && !rd0_dat_rdy |=> rd0_dat_vld && $stable(rd0_dat))
        else $error("rd0 data changed before transfer");
    a_rd1_dat_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rd1_dat_vld && !rd1_dat_rdy |=> rd1_dat_vld && $stable(rd1_dat))
        else $error("rd1 data changed before transfer");
    a_wr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wr_vld && !wr_rdy |=> wr_vld && $stable(wr_addr) && $stable(wr_dat))
        else $error("write valid or payload changed before transfer");

    // ============================
    // Completion pulses
    // ============================
    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else $error("done longer than one cycle");
    a_err_pulse: assert property (@(posedge clk) disable iff (!rst_n) err |=> !err)
        else $error("err longer than one cycle");

endmodule

bind opu_top opu_sva u_sva (
    .clk(clk), .rst_n(rst_n),
    .cfg_vld(cfg_vld), .cfg_rdy(cfg_rdy), .cfg_info(cfg_info),
    .rd0_addr(rd0_addr), .rd0_addr_vld(rd0_addr_vld), .rd0_addr_rdy(rd0_addr_rdy),
    .rd0_dat(rd0_dat), .rd0_dat_vld(rd0_dat_vld), .rd0_dat_rdy(rd0_dat_rdy),
    .rd1_addr(rd1_addr), .rd1_addr_vld(rd1_addr_vld), .rd1_addr_rdy(rd1_addr_rdy),
    .rd1_dat(rd1_dat), .rd1_dat_vld(rd1_dat_vld), .rd1_dat_rdy(rd1_dat_rdy),
    .wr_addr(wr_addr), .wr_dat(wr_dat), .wr_vld(wr_vld), .wr_rdy(wr_rdy),
    .done(done), .err(err)
);

`default_nettype wire

//--- test/opu_tb.sv
/* Operation unit testbench
   Buffer model with random stalls, command sequence and write checking */
`default_nettype none

module opu_tb;

    localparam int TIMEOUT = 2000;

    logic            clk;
    logic            rst_n        = 1'b0;
    logic            cfg_vld      = 1'b0;
    logic            cfg_rdy;
    opu_pkg::cfg_t   cfg_info     = '0;
    opu_pkg::addr_t  rd0_addr;
    logic            rd0_addr_vld;
    logic            rd0_addr_rdy = 1'b0;
    opu_pkg::word_t  rd0_dat      = '0;
    logic            rd0_dat_vld  = 1'b0;
    logic            rd0_dat_rdy;
    opu_pkg::addr_t  rd1_addr;
    logic            rd1_addr_vld;
    logic            rd1_addr_rdy = 1'b0;
    opu_pkg::word_t  rd1_dat      = '0;
    logic            rd1_dat_vld  = 1'b0;
    logic            rd1_dat_rdy;
    opu_pkg::addr_t  wr_addr;
    opu_pkg::word_t  wr_dat;
    logic            wr_vld;
    logic            wr_rdy       = 1'b0;
    logic            done;
    logic            err;

    integer          seed         = 55672;
    int              done_cnt     = 0;
    int              cmds_sent    = 0;
    logic            reject_phase = 1'b0;
    opu_pkg::addr_t  rq0 [$];
    opu_pkg::addr_t  rq1 [$];
    opu_pkg::addr_t  exp_rd0 [$];
    opu_pkg::addr_t  exp_rd1 [$];
    opu_pkg::addr_t  exp_addr [$];
    opu_pkg::word_t  exp_dat [$];
    logic            exp_err [$];
    opu_pkg::addr_t  want_r;
    opu_pkg::addr_t  want_a;
    opu_pkg::word_t  want_d;
    logic            want_e;

    opu_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ============================
    // Failure reporting
    // ============================
    task automatic halt_on_failure();
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        halt_on_failure();
    endtask

    task automatic report_mismatch(input string name, input opu_pkg::word_t exp,
                                   input opu_pkg::word_t got);
        $display("FAIL %0t %s expected %h got %h", $time, name, exp, got);
        halt_on_failure();
    endtask

    task automatic expect_bit(input string name, input logic exp, input logic got);
        assert (got == exp)
            else report_mismatch(name, opu_pkg::word_t'(exp), opu_pkg::word_t'(got));
    endtask

    // Lane k of the word at address a holds a[7:0] + 17k
    function automatic opu_pkg::word_t model_word(input opu_pkg::addr_t a);
        opu_pkg::word_t w;
        for (int k = 0; k < opu_pkg::LANES; k++) begin
            w[k*opu_pkg::DATA_W +: opu_pkg::DATA_W] = opu_pkg::lane_t'(int'(a[7:0]) + 17 * k);
        end
        return w;
    endfunction

    function automatic opu_pkg::word_t lane_sum(input opu_pkg::word_t x, input opu_pkg::word_t y);
        opu_pkg::word_t s;
        for (int k = 0; k < opu_pkg::LANES; k++) begin
            s[k*opu_pkg::DATA_W +: opu_pkg::DATA_W] = opu_pkg::lane_t'(
                int'(x[k*opu_pkg::DATA_W +: opu_pkg::DATA_W])
                + int'(y[k*opu_pkg::DATA_W +: opu_pkg::DATA_W]));
        end
        return s;
    endfunction

    function automatic opu_pkg::cfg_t pack_cmd(input opu_pkg::opc_t opc, input opu_pkg::len_t len,
                                               input opu_pkg::addr_t s0, input opu_pkg::addr_t s1,
                                               input opu_pkg::addr_t d);
        opu_pkg::cfg_t c;
        c = '0;
        c[opu_pkg::LEN_LSB +: opu_pkg::LEN_W]   = len;
        c[opu_pkg::OPC_LSB +: opu_pkg::OPC_W]   = opc;
        c[opu_pkg::SRC0_LSB +: opu_pkg::ADDR_W] = s0;
        c[opu_pkg::SRC1_LSB +: opu_pkg::ADDR_W] = s1;
        c[opu_pkg::DST_LSB +: opu_pkg::ADDR_W]  = d;
        return c;
    endfunction

    // ============================
    // Command driver
    // ============================
    task automatic send_cmd(input opu_pkg::opc_t opc, input opu_pkg::len_t len,
                            input opu_pkg::addr_t s0, input opu_pkg::addr_t s1,
                            input opu_pkg::addr_t d, input string name);
        int   cycles;
        logic ok;
        cycles = 0;
        ok = ((opc == opu_pkg::OPC_ADD) || (opc == opu_pkg::OPC_CAT)) && (len != '0);
        cfg_vld  <= 1'b1;
        cfg_info <= pack_cmd(opc, len, s0, s1, d);
        @(posedge clk);
        while (!cfg_rdy) begin
            if (cycles >= TIMEOUT) begin
                abort_run($sformatf("%s was never accepted", name));
            end else begin
                cycles++;
                @(posedge clk);
            end
        end
        cfg_vld <= 1'b0;
        cmds_sent++;
        exp_err.push_back(!ok);
        // Both operations read len words from each source in order
        if (ok) begin
            for (int i = 0; i < int'(len); i++) begin
                exp_rd0.push_back(opu_pkg::addr_t'(int'(s0) + i));
                exp_rd1.push_back(opu_pkg::addr_t'(int'(s1) + i));
            end
        end
        // Expected writes follow from the command fields
        if (ok && (opc == opu_pkg::OPC_ADD)) begin
            for (int i = 0; i < int'(len); i++) begin
                exp_addr.push_back(opu_pkg::addr_t'(int'(d) + i));
                exp_dat.push_back(lane_sum(model_word(opu_pkg::addr_t'(int'(s0) + i)),
                                           model_word(opu_pkg::addr_t'(int'(s1) + i))));
            end
        end else if (ok) begin
            for (int i = 0; i < int'(len); i++) begin
                exp_addr.push_back(opu_pkg::addr_t'(int'(d) + i));
                exp_dat.push_back(model_word(opu_pkg::addr_t'(int'(s0) + i)));
            end
            for (int i = 0; i < int'(len); i++) begin
                exp_addr.push_back(opu_pkg::addr_t'(int'(d) + int'(len) + i));
                exp_dat.push_back(model_word(opu_pkg::addr_t'(int'(s1) + i)));
            end
        end
    endtask

    task automatic wait_for_done(input string name);
        int cycles;
        cycles = 0;
        while (done_cnt < cmds_sent) begin
            if (cycles >= TIMEOUT) begin
                abort_run($sformatf("%s did not finish within the timeout", name));
            end else begin
                cycles++;
                @(posedge clk);
            end
        end
    endtask

    // ============================
    // Buffer model and stalls
    // ============================
    always @(posedge clk) begin
        rd0_addr_rdy <= (($random(seed) & 3) != 0);
        rd1_addr_rdy <= (($random(seed) & 3) != 0);
        wr_rdy       <= (($random(seed) & 3) != 0);
        if (rd0_addr_vld && rd0_addr_rdy) begin
            assert (exp_rd0.size() > 0)
                else abort_run("read on channel 0 with no read expected");
            if (exp_rd0.size() > 0) begin
                want_r = exp_rd0.pop_front();
                assert (rd0_addr == want_r)
                    else report_mismatch("rd0_addr", opu_pkg::word_t'(want_r),
                                         opu_pkg::word_t'(rd0_addr));
            end
            rq0.push_back(rd0_addr);
        end
        if (rd1_addr_vld && rd1_addr_rdy) begin
            assert (exp_rd1.size() > 0)
                else abort_run("read on channel 1 with no read expected");
            if (exp_rd1.size() > 0) begin
                want_r = exp_rd1.pop_front();
                assert (rd1_addr == want_r)
                    else report_mismatch("rd1_addr", opu_pkg::word_t'(want_r),
                                         opu_pkg::word_t'(rd1_addr));
            end
            rq1.push_back(rd1_addr);
        end
        // Data returns in address order and holds until taken
        if (!rd0_dat_vld || rd0_dat_rdy) begin
            if ((rq0.size() > 0) && (($random(seed) & 3) != 0)) begin
                rd0_dat     <= model_word(rq0.pop_front());
                rd0_dat_vld <= 1'b1;
            end else begin
                rd0_dat_vld <= 1'b0;
            end
        end
        if (!rd1_dat_vld || rd1_dat_rdy) begin
            if ((rq1.size() > 0) && (($random(seed) & 3) != 0)) begin
                rd1_dat     <= model_word(rq1.pop_front());
                rd1_dat_vld <= 1'b1;
            end else begin
                rd1_dat_vld <= 1'b0;
            end
        end
    end

    // Write and completion monitor
    always @(posedge clk) begin
        if (rst_n) begin
            assert (!(reject_phase && (rd0_addr_vld || rd1_addr_vld || wr_vld)))
                else abort_run("buffer traffic during a rejected command");
            assert (!err || done)
                else abort_run("err raised without done");
            if (wr_vld && wr_rdy) begin
                assert (exp_addr.size() > 0)
                    else abort_run("write transfer with no write expected");
                if (exp_addr.size() > 0) begin
                    want_a = exp_addr.pop_front();
                    want_d = exp_dat.pop_front();
                    assert (wr_addr == want_a)
                        else report_mismatch("wr_addr", opu_pkg::word_t'(want_a),
                                             opu_pkg::word_t'(wr_addr));
                    assert (wr_dat == want_d)
                        else report_mismatch("wr_dat", want_d, wr_dat);
                end
            end
            if (done) begin
                done_cnt <= done_cnt + 1;
                assert (exp_addr.size() == 0)
                    else abort_run("done came before all writes of the command");
                assert (exp_err.size() > 0)
                    else abort_run("done pulse with no command outstanding");
                if (exp_err.size() > 0) begin
                    want_e = exp_err.pop_front();
                    assert (err == want_e)
                        else report_mismatch("err", opu_pkg::word_t'(want_e),
                                             opu_pkg::word_t'(err));
                end
            end
        end
    end

    // ============================
    // Command sequence
    // ============================
    initial begin
        int prev;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        expect_bit("cfg_rdy", 1'b1, cfg_rdy);
        expect_bit("rd0_addr_vld", 1'b0, rd0_addr_vld);
        expect_bit("rd1_addr_vld", 1'b0, rd1_addr_vld);
        expect_bit("rd0_dat_rdy", 1'b0, rd0_dat_rdy);
        expect_bit("rd1_dat_rdy", 1'b0, rd1_dat_rdy);
        expect_bit("wr_vld", 1'b0, wr_vld);
        expect_bit("done", 1'b0, done);
        expect_bit("err", 1'b0, err);

        send_cmd(opu_pkg::OPC_ADD, 12'd5, 16'h0010, 16'h0120, 16'h0800, "ADD of length 5");
        wait_for_done("ADD of length 5");
        send_cmd(opu_pkg::OPC_CAT, 12'd3, 16'h0233, 16'h03f0, 16'h0900, "CAT of length 3");
        wait_for_done("CAT of length 3");

        // Rejected commands must cause no buffer traffic
        reject_phase <= 1'b1;
        send_cmd(opu_pkg::OPC_KNN, 12'd4, 16'h0040, 16'h0050, 16'h0a00, "KNN command");
        wait_for_done("KNN command");
        send_cmd(opu_pkg::OPC_SHF, 12'd4, 16'h0040, 16'h0050, 16'h0a00, "SHF command");
        wait_for_done("SHF command");
        send_cmd(opu_pkg::OPC_ADD, 12'd0, 16'h0040, 16'h0050, 16'h0a00, "ADD of length 0");
        wait_for_done("ADD of length 0");
        reject_phase <= 1'b0;

        // Second command waits behind the first
        send_cmd(opu_pkg::OPC_CAT, 12'd3, 16'h10fe, 16'h2081, 16'h0b00, "first CAT of a pair");
        prev = done_cnt;
        send_cmd(opu_pkg::OPC_ADD, 12'd5, 16'h30c0, 16'h40d0, 16'h0c00, "queued ADD");
        assert (done_cnt == prev + 1)
            else report_mismatch("done_cnt", opu_pkg::word_t'(prev + 1),
                                 opu_pkg::word_t'(done_cnt));
        wait_for_done("queued ADD");

        repeat (4) @(posedge clk);
        if ((exp_addr.size() == 0) && (exp_err.size() == 0)
            && (exp_rd0.size() == 0) && (exp_rd1.size() == 0)) begin
            $display("All tests passed");
            $finish;
        end else begin
            abort_run("expected reads, writes or completions are missing at the end");
        end
    end

endmodule

`default_nettype wire

//--- verilog/opu_decode.sv
/* Command decode
   Accepts a command, splits its fields and either starts it or rejects it */
`default_nettype none

module opu_decode (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cfg_vld,
    input  opu_pkg::cfg_t      cfg_info,
    input  logic               fin,
    output logic               cfg_rdy,
    output logic               start,
    output logic               op_cat,
    output opu_pkg::addr_t     src0,
    output opu_pkg::addr_t     src1,
    output opu_pkg::addr_t     dst,
    output opu_pkg::len_t      len,
    output logic               done,
    output logic               err
);

    opu_pkg::dec_state_e state;
    opu_pkg::opc_t       opc;
    opu_pkg::len_t       cmd_len;
    logic                cfg_xfer;
    logic                bad_cmd;

    assign cfg_rdy  = (state == opu_pkg::DEC_IDLE);
    assign cfg_xfer = cfg_vld && cfg_rdy;

    assign opc     = cfg_info[opu_pkg::OPC_LSB +: opu_pkg::OPC_W];
    assign cmd_len = cfg_info[opu_pkg::LEN_LSB +: opu_pkg::LEN_W];

    // Only ADD and CAT with a nonzero length reach the datapath
    assign bad_cmd = !((opc == opu_pkg::OPC_ADD) || (opc == opu_pkg::OPC_CAT))
                     || (cmd_len == '0);

    // ============================
    // Busy tracking
    // ============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= opu_pkg::DEC_IDLE;
            start <= 1'b0;
            done  <= 1'b0;
            err   <= 1'b0;
        end else begin
            start <= cfg_xfer && !bad_cmd;
            // Rejects finish right away, accepted commands wait for fin
            done  <= (cfg_xfer && bad_cmd) || fin;
            err   <= cfg_xfer && bad_cmd;
            case (state)
                opu_pkg::DEC_IDLE: begin
                    if (cfg_xfer) begin
                        state <= opu_pkg::DEC_BUSY;
                    end
                end
                default: begin
                    if (done) begin
                        state <= opu_pkg::DEC_IDLE;
                    end
                end
            endcase
        end
    end

    // Field capture
    always_ff @(posedge clk) begin
        if (cfg_xfer) begin
            op_cat <= (opc == opu_pkg::OPC_CAT);
            src0   <= cfg_info[opu_pkg::SRC0_LSB +: opu_pkg::ADDR_W];
            src1   <= cfg_info[opu_pkg::SRC1_LSB +: opu_pkg::ADDR_W];
            dst    <= cfg_info[opu_pkg::DST_LSB +: opu_pkg::ADDR_W];
            len    <= cmd_len;
        end
    end

endmodule

`default_nettype wire

//--- verilog/opu_execute.sv
/* Execute stage
   Issues buffer reads on both channels and forms ADD sums or CAT copies */
`default_nettype none

module opu_execute (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start,
    input  logic            op_cat,
    input  opu_pkg::addr_t  src0,
    input  opu_pkg::addr_t  src1,
    input  opu_pkg::len_t   len,
    output opu_pkg::addr_t  rd0_addr,
    output logic            rd0_addr_vld,
    input  logic            rd0_addr_rdy,
    input  opu_pkg::word_t  rd0_dat,
    input  logic            rd0_dat_vld,
    output logic            rd0_dat_rdy,
    output opu_pkg::addr_t  rd1_addr,
    output logic            rd1_addr_vld,
    input  logic            rd1_addr_rdy,
    input  opu_pkg::word_t  rd1_dat,
    input  logic            rd1_dat_vld,
    output logic            rd1_dat_rdy,
    output logic            out_vld,
    input  logic            out_rdy,
    output opu_pkg::word_t  out_dat,
    output logic            out_last
);

    opu_pkg::exe_state_e state;
    logic                cat_q;
    opu_pkg::len_t       len_q;
    opu_pkg::len_t       len_m1;
    opu_pkg::addr_t      addr_q  [2];
    opu_pkg::len_t       iss_cnt [2];
    opu_pkg::len_t       rcv_cnt [2];
    logic [1:0]          outst   [2];
    logic [1:0]          ch_act;
    logic [1:0]          addr_vld;
    logic [1:0]          addr_xfer;
    logic [1:0]          dat_rdy;
    logic [1:0]          dat_xfer;
    logic                can_acc;
    logic                take;
    logic                last_word;
    opu_pkg::word_t      sum_dat;

    // ============================
    // Read address issue
    // ============================
    assign ch_act[0] = (state == opu_pkg::EXE_RUN_A);
    assign ch_act[1] = ((state == opu_pkg::EXE_RUN_A) && !cat_q) || (state == opu_pkg::EXE_RUN_B);

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            addr_vld[i] = ch_act[i] && (iss_cnt[i] != len_q) && (outst[i] != 2'd2);
        end
    end

    assign rd0_addr     = addr_q[0];
    assign rd1_addr     = addr_q[1];
    assign rd0_addr_vld = addr_vld[0];
    assign rd1_addr_vld = addr_vld[1];
    assign addr_xfer    = addr_vld & {rd1_addr_rdy, rd0_addr_rdy};

    // ============================
    // Read data acceptance
    // ============================
    assign can_acc = !out_vld || out_rdy;

    // ADD pairs one word from each channel in the same cycle
    always_comb begin
        if (!cat_q) begin
            dat_rdy[0] = ch_act[0] && can_acc && rd1_dat_vld;
            dat_rdy[1] = ch_act[1] && can_acc && rd0_dat_vld;
        end else begin
            dat_rdy[0] = ch_act[0] && can_acc;
            dat_rdy[1] = ch_act[1] && can_acc;
        end
    end

    assign rd0_dat_rdy = dat_rdy[0];
    assign rd1_dat_rdy = dat_rdy[1];
    assign dat_xfer    = dat_rdy & {rd1_dat_vld, rd0_dat_vld};
    assign take        = |dat_xfer;
    assign len_m1      = len_q - 1'b1;

    // Final word of ADD, or of the second vector of CAT
    assign last_word = (state == opu_pkg::EXE_RUN_B) ? (rcv_cnt[1] == len_m1)
                     : (!cat_q && (rcv_cnt[0] == len_m1));

    // Lane-wise sum modulo 256 per lane
    always_comb begin
        for (int k = 0; k < opu_pkg::LANES; k++) begin
            sum_dat[k*opu_pkg::DATA_W +: opu_pkg::DATA_W] =
                opu_pkg::lane_t'(rd0_dat[k*opu_pkg::DATA_W +: opu_pkg::DATA_W]
                               + rd1_dat[k*opu_pkg::DATA_W +: opu_pkg::DATA_W]);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= opu_pkg::EXE_IDLE;
            cat_q   <= 1'b0;
            len_q   <= '0;
            out_vld <= 1'b0;
            for (int i = 0; i < 2; i++) begin
                iss_cnt[i] <= '0;
                rcv_cnt[i] <= '0;
                outst[i]   <= 2'd0;
            end
        end else begin
            if (start) begin
                state <= opu_pkg::EXE_RUN_A;
                cat_q <= op_cat;
                len_q <= len;
            end else if (take && (state == opu_pkg::EXE_RUN_A) && (rcv_cnt[0] == len_m1)) begin
                state <= cat_q ? opu_pkg::EXE_RUN_B : opu_pkg::EXE_IDLE;
            end else if (take && last_word) begin
                state <= opu_pkg::EXE_IDLE;
            end
            for (int i = 0; i < 2; i++) begin
                if (start) begin
                    iss_cnt[i] <= '0;
                    rcv_cnt[i] <= '0;
                end else begin
                    if (addr_xfer[i]) begin
                        iss_cnt[i] <= iss_cnt[i] + 1'b1;
                    end
                    if (dat_xfer[i]) begin
                        rcv_cnt[i] <= rcv_cnt[i] + 1'b1;
                    end
                end
                // Reads in flight on this channel
                if (addr_xfer[i] && !dat_xfer[i]) begin
                    outst[i] <= outst[i] + 2'd1;
                end else if (!addr_xfer[i] && dat_xfer[i]) begin
                    outst[i] <= outst[i] - 2'd1;
                end
            end
            if (take) begin
                out_vld <= 1'b1;
            end else if (out_rdy) begin
                out_vld <= 1'b0;
            end
        end
    end

    // Address pointers and output word
    always_ff @(posedge clk) begin
        if (start) begin
            addr_q[0] <= src0;
            addr_q[1] <= src1;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (addr_xfer[i]) begin
                    addr_q[i] <= addr_q[i] + 1'b1;
                end
            end
        end
        if (take) begin
            out_dat  <= !cat_q ? sum_dat : (dat_xfer[0] ? rd0_dat : rd1_dat);
            out_last <= last_word;
        end
    end

endmodule

`default_nettype wire

//--- verilog/opu_pkg.sv
/* Shared operation unit definitions
   Widths, command word layout, opcodes and common types */
`default_nettype none

package opu_pkg;

    // ============================
    // Widths
    // ============================
    localparam int DATA_W = 8;
    localparam int LANES  = 4;
    localparam int WORD_W = DATA_W * LANES;
    localparam int ADDR_W = 16;
    localparam int LEN_W  = 12;
    localparam int CFG_W  = 64;
    localparam int OPC_W  = 3;

    // Command word fields
    localparam int LEN_LSB  = 0;
    localparam int OPC_LSB  = 12;
    localparam int SRC0_LSB = 16;
    localparam int SRC1_LSB = 32;
    localparam int DST_LSB  = 48;

    // ============================
    // Types
    // ============================
    typedef logic [WORD_W-1:0] word_t;
    typedef logic [DATA_W-1:0] lane_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [LEN_W-1:0]  len_t;
    typedef logic [CFG_W-1:0]  cfg_t;
    typedef logic [OPC_W-1:0]  opc_t;

    // Opcode values of the command field
    localparam opc_t OPC_KNN = 3'd0;
    localparam opc_t OPC_SHF = 3'd1;
    localparam opc_t OPC_ADD = 3'd2;
    localparam opc_t OPC_CAT = 3'd3;

    typedef enum logic {
        DEC_IDLE,
        DEC_BUSY
    } dec_state_e;

    typedef enum logic [1:0] {
        EXE_IDLE,
        EXE_RUN_A,
        EXE_RUN_B
    } exe_state_e;

endpackage

`default_nettype wire

//--- verilog/opu_result.sv
/* Result write-back
   Two-entry queue in front of the buffer write channel */
`default_nettype none

module opu_result (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start,
    input  opu_pkg::addr_t  dst,
    input  logic            out_vld,
    output logic            out_rdy,
    input  opu_pkg::word_t  out_dat,
    input  logic            out_last,
    output opu_pkg::addr_t  wr_addr,
    output opu_pkg::word_t  wr_dat,
    output logic            wr_vld,
    input  logic            wr_rdy,
    output logic            fin
);

    opu_pkg::word_t q_dat  [2];
    logic           q_last [2];
    logic           wr_ptr;
    logic           rd_ptr;
    logic [1:0]     count;
    logic           push;
    logic           pop;

    assign out_rdy = (count != 2'd2);
    assign wr_vld  = (count != 2'd0);
    assign wr_dat  = q_dat[rd_ptr];
    assign push    = out_vld && out_rdy;
    assign pop     = wr_vld && wr_rdy;

    // ============================
    // Queue control
    // ============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
            fin    <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop) begin
                rd_ptr <= ~rd_ptr;
            end
            if (push && !pop) begin
                count <= count + 2'd1;
            end else if (!push && pop) begin
                count <= count - 2'd1;
            end
            // Command complete once its last word is written
            fin <= pop && q_last[rd_ptr];
        end
    end

    // Queue storage
    always_ff @(posedge clk) begin
        if (push) begin
            q_dat[wr_ptr]  <= out_dat;
            q_last[wr_ptr] <= out_last;
        end
    end

    // Destination walks up from dst
    always_ff @(posedge clk) begin
        if (start) begin
            wr_addr <= dst;
        end else if (pop) begin
            wr_addr <= wr_addr + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- verilog/opu_top.sv
/* Shared operation unit top level
   Decode, execute and write-back around the on-chip buffer ports */
`default_nettype none

module opu_top (
    input  logic            clk,
    input  logic            rst_n,

    // Command channel
    input  logic            cfg_vld,
    output logic            cfg_rdy,
    input  opu_pkg::cfg_t   cfg_info,

    // Read channel 0
    output opu_pkg::addr_t  rd0_addr,
    output logic            rd0_addr_vld,
    input  logic            rd0_addr_rdy,
    input  opu_pkg::word_t  rd0_dat,
    input  logic            rd0_dat_vld,
    output logic            rd0_dat_rdy,

    // Read channel 1
    output opu_pkg::addr_t  rd1_addr,
    output logic            rd1_addr_vld,
    input  logic            rd1_addr_rdy,
    input  opu_pkg::word_t  rd1_dat,
    input  logic            rd1_dat_vld,
    output logic            rd1_dat_rdy,

    // Write channel
    output opu_pkg::addr_t  wr_addr,
    output opu_pkg::word_t  wr_dat,
    output logic            wr_vld,
    input  logic            wr_rdy,

    // Completion
    output logic            done,
    output logic            err
);

    // ============================
    // Internal links
    // ============================
    logic            start;
    logic            op_cat;
    opu_pkg::addr_t  src0;
    opu_pkg::addr_t  src1;
    opu_pkg::addr_t  dst;
    opu_pkg::len_t   len;
    logic            fin;
    logic            out_vld;
    logic            out_rdy;
    opu_pkg::word_t  out_dat;
    logic            out_last;

    opu_decode u_decode (.*);

    opu_execute u_execute (.*);

    opu_result u_result (.*);

endmodule

`default_nettype wire
